/* tb.f */
common/rename_pkg.sv
free_list/free_list_fifo.sv
verilog/reg_alias_table.sv
verilog/rename_stage.sv
verilog/rename_top.sv
sim/rename_tb.sv

/* Bender.yml */
package:
  name: rename_frontend

sources:
  # Shared package first
  - common/rename_pkg.sv
  # RTL
  - free_list/free_list_fifo.sv
  - verilog/reg_alias_table.sv
  - verilog/rename_stage.sv
  - verilog/rename_top.sv
  # Testbench
  - target: simulation
    files:
      - sim/rename_tb.sv

/* sim/rename_tb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the rename front end at default sizes, 32 arch and
// 64 physical registers.
// One instruction in flight at a time. Each row finishes with the
// output slot drained before the next row starts.
// Commit rows return old_prd values in the order they were received.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rename_tb;

	import rename_pkg::*;

	localparam logic OP_RENAME = 1'b0;
	localparam logic OP_COMMIT = 1'b1;

	// One stimulus row, exp_free is free_count after the last repeat
	typedef struct packed {
		logic       op;
		arch_tag_t  rs1;
		arch_tag_t  rs2;
		arch_tag_t  rd;
		logic       rd_valid;
		logic [3:0] hold;     // Cycles with out_ready low after accept
		logic       rnd;      // Take rs1, rs2, rd from the generator
		logic [7:0] reps;
		logic [6:0] exp_free;
	} row_t;

	logic        clk = 1'b0;
	logic        reset;
	logic        in_valid;
	rename_req_t in_req;
	logic        in_ready;
	logic        out_valid;
	rename_rsp_t out_rsp;
	logic        out_ready;
	logic        commit_valid;
	phys_tag_t   commit_tag;
	logic [6:0]  free_count;

	row_t        rows [16];
	int          num_rows = 0;
	int          total_apps = 0;
	logic [31:0] rng_state;

	// Reference model
	phys_tag_t   map_model [ARCH_REGS];
	phys_tag_t   free_q [$];     // Free tags, front is next allocation
	phys_tag_t   retire_q [$];   // old_prd values waiting for commit

	rename_top dut_i (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.in_req       (in_req),
		.in_ready     (in_ready),
		.out_valid    (out_valid),
		.out_rsp      (out_rsp),
		.out_ready    (out_ready),
		.commit_valid (commit_valid),
		.commit_tag   (commit_tag),
		.free_count   (free_count)
	);

	always #4 clk = ~clk; // 8 ns period

	function automatic logic [31:0] next_random();
		logic [31:0] s;
		s = rng_state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rng_state = s;
		return s;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] time %0t: %s = %0h, expected %0h", $time, name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic add_row(input logic op, input int rs1, input int rs2, input int rd,
			input logic rd_valid, input int hold, input logic rnd, input int reps,
			input int exp_free);
		rows[num_rows] = '{op, arch_tag_t'(rs1), arch_tag_t'(rs2), arch_tag_t'(rd),
			rd_valid, 4'(hold), rnd, 8'(reps), 7'(exp_free)};
		num_rows++;
		total_apps += reps;
	endtask

	task automatic run_rename(input row_t r);
		rename_req_t req;
		rename_rsp_t exp_rsp;
		logic        exp_ready;
		logic [31:0] rv;
		req.rs1      = r.rs1;
		req.rs2      = r.rs2;
		req.rd       = r.rd;
		req.rd_valid = r.rd_valid;
		if (r.rnd) begin
			rv      = next_random();
			req.rs1 = rv[4:0];
			req.rs2 = rv[9:5];
			req.rd  = rv[14:10];
		end
		exp_ready = !req.rd_valid || (free_q.size() != 0); // Slot is empty here
		@(posedge clk);
		in_valid  <= 1'b1;
		in_req    <= req;
		out_ready <= (r.hold == 0);
		@(negedge clk);
		check_value("in_ready", in_ready, exp_ready);
		if (!exp_ready) begin
			// Stalled on an empty free list, nothing may come out
			repeat (3) begin
				@(negedge clk);
				check_value("in_ready", in_ready, 1'b0);
				check_value("out_valid", out_valid, 1'b0);
			end
			@(posedge clk);
			in_valid <= 1'b0;
		end else begin
			// Expected lookups use the mapping before this instruction
			exp_rsp.prs1     = map_model[req.rs1];
			exp_rsp.prs2     = map_model[req.rs2];
			exp_rsp.rd_valid = req.rd_valid;
			exp_rsp.prd      = req.rd_valid ? free_q[0] : '0;
			exp_rsp.old_prd  = req.rd_valid ? map_model[req.rd] : '0;
			@(posedge clk); // Accepting edge
			in_valid <= 1'b0;
			if (req.rd_valid) begin
				free_q.delete(0);
				map_model[req.rd] = exp_rsp.prd;
				retire_q.push_back(exp_rsp.old_prd);
			end
			@(negedge clk);
			check_value("out_valid", out_valid, 1'b1);
			check_value("out_rsp.prs1", out_rsp.prs1, exp_rsp.prs1);
			check_value("out_rsp.prs2", out_rsp.prs2, exp_rsp.prs2);
			check_value("out_rsp.prd", out_rsp.prd, exp_rsp.prd);
			check_value("out_rsp.old_prd", out_rsp.old_prd, exp_rsp.old_prd);
			check_value("out_rsp.rd_valid", out_rsp.rd_valid, exp_rsp.rd_valid);
			check_value("free_count", free_count, free_q.size());
			// Back-pressure, slot must hold
			repeat (r.hold) begin
				@(posedge clk);
				@(negedge clk);
				check_value("out_valid", out_valid, 1'b1);
				check_value("out_rsp", out_rsp, exp_rsp);
				check_value("in_ready", in_ready, 1'b0);
			end
			if (r.hold != 0) begin
				@(posedge clk);
				out_ready <= 1'b1;
				@(negedge clk);
				check_value("out_rsp", out_rsp, exp_rsp); // Still unchanged
			end
			@(posedge clk); // Output transfer
			@(negedge clk);
			check_value("out_valid", out_valid, 1'b0);
		end
	endtask

	task automatic run_commit();
		phys_tag_t tag;
		if (retire_q.size() == 0) begin
			$display("Commit row found no retired tag left to return");
			$display("*** TEST FAILED ***");
			$fatal(1, "Stimulus table out of order");
		end else begin
			tag = retire_q.pop_front();
			free_q.push_back(tag);
			@(posedge clk);
			commit_valid <= 1'b1;
			commit_tag   <= tag;
			@(posedge clk); // Push edge
			commit_valid <= 1'b0;
			@(negedge clk);
			check_value("free_count", free_count, free_q.size());
		end
	endtask

	// Watchdog
	initial begin
		wait (total_apps > 0);
		repeat (total_apps * 50) @(posedge clk);
		$display("Timeout, the test rows did not finish in %0d cycles", total_apps * 50);
		$display("*** TEST FAILED ***");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		reset        = 1'b1;
		in_valid     = 1'b0;
		in_req       = '0;
		out_ready    = 1'b1;
		commit_valid = 1'b0;
		commit_tag   = '0;
		rng_state    = 32'd32460;
		for (int i = 0; i < ARCH_REGS; i++) begin
			map_model[i] = phys_tag_t'(i); // Identity
		end
		for (int i = ARCH_REGS; i < PHYS_REGS; i++) begin
			free_q.push_back(phys_tag_t'(i));
		end

		//      op         rs1 rs2 rd rdv hold rnd reps free
		add_row(OP_RENAME, 3,  7,  3, 1,  0,   0,  1,   31); // Identity, rs1 == rd
		add_row(OP_RENAME, 3,  3,  4, 1,  0,   0,  1,   30); // Depends on tag 32
		add_row(OP_RENAME, 4,  1,  8, 0,  0,   0,  1,   30); // No destination
		add_row(OP_RENAME, 4,  3,  9, 1,  3,   0,  1,   29); // Back-pressure
		add_row(OP_RENAME, 0,  0,  0, 1,  0,   1,  29,  0);  // Drain free list
		add_row(OP_RENAME, 1,  2,  5, 1,  0,   0,  1,   0);  // Blocked
		add_row(OP_RENAME, 1,  2,  0, 0,  0,   0,  1,   0);  // Passes while empty
		add_row(OP_COMMIT, 0,  0,  0, 0,  0,   0,  3,   3);
		add_row(OP_RENAME, 0,  0,  0, 1,  1,   1,  3,   0);  // Gets 3, 4, 9 back
		add_row(OP_RENAME, 6,  6,  6, 1,  0,   0,  1,   0);  // Blocked again
		add_row(OP_COMMIT, 0,  0,  0, 0,  0,   0,  4,   4);
		add_row(OP_RENAME, 0,  0,  0, 1,  2,   1,  2,   2);
		add_row(OP_RENAME, 0,  0,  0, 0,  0,   1,  2,   2);

		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("free_count", free_count, 32); // Before any traffic

		for (int i = 0; i < num_rows; i++) begin
			repeat (rows[i].reps) begin
				if (rows[i].op == OP_COMMIT) begin
					run_commit();
				end else begin
					run_rename(rows[i]);
				end
			end
			check_value("free_count", free_count, rows[i].exp_free);
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* verilog/rename_top.sv */
//////////////////////////////////////////////////////////////////////
// Rename front end top level.
// Built for 32 architectural and 64 physical registers, matching the
// tag widths in the shared package.
// Commit must only return tags previously delivered as old_prd.
// One cycle latency from in to out.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rename_top #(
	parameter int NUM_ARCH = rename_pkg::ARCH_REGS,
	parameter int NUM_PHYS = rename_pkg::PHYS_REGS
) (
	input  logic                      clk,
	input  logic                      reset,

	input  logic                      in_valid,
	input  rename_pkg::rename_req_t   in_req,
	output logic                      in_ready,

	output logic                      out_valid,
	output rename_pkg::rename_rsp_t   out_rsp,
	input  logic                      out_ready,

	// Retired tags back to the free list, no ready
	input  logic                      commit_valid,
	input  rename_pkg::phys_tag_t     commit_tag,

	output logic [$clog2(NUM_PHYS):0] free_count
);

	import rename_pkg::*;

	localparam int FL_DEPTH_LOG2 = $clog2(NUM_PHYS);

	phys_tag_t fl_head;
	logic      fl_empty;
	logic      fl_pop;
	phys_tag_t rat_prs1;
	phys_tag_t rat_prs2;
	phys_tag_t rat_old;
	logic      rat_wr_en;
	phys_tag_t rat_wr_tag;

	// Tags above the identity map start out free
	free_list_fifo #(
		.DEPTH_LOG2    (FL_DEPTH_LOG2),
		.PRELOAD_START (NUM_ARCH),
		.PRELOAD_COUNT (NUM_PHYS - NUM_ARCH)
	) free_list_i (
		.clk        (clk),
		.reset      (reset),
		.push       (commit_valid),
		.push_tag   (commit_tag),
		.pop        (fl_pop),
		.head       (fl_head),
		.empty      (fl_empty),
		.free_count (free_count)
	);

	// Lookups and write address come straight from the request
	reg_alias_table #(
		.NUM_ARCH (NUM_ARCH)
	) rat_i (
		.clk      (clk),
		.reset    (reset),
		.rd_addr1 (in_req.rs1),
		.rd_addr2 (in_req.rs2),
		.rd_tag1  (rat_prs1),
		.rd_tag2  (rat_prs2),
		.old_addr (in_req.rd),
		.old_tag  (rat_old),
		.wr_en    (rat_wr_en),
		.wr_addr  (in_req.rd),
		.wr_tag   (rat_wr_tag)
	);

	rename_stage stage_i (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_req     (in_req),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_rsp    (out_rsp),
		.out_ready  (out_ready),
		.fl_head    (fl_head),
		.fl_empty   (fl_empty),
		.fl_pop     (fl_pop),
		.rat_prs1   (rat_prs1),
		.rat_prs2   (rat_prs2),
		.rat_old    (rat_old),
		.rat_wr_en  (rat_wr_en),
		.rat_wr_tag (rat_wr_tag)
	);

endmodule

/* verilog/rename_stage.sv */
//////////////////////////////////////////////////////////////////////
// Rename stage control with a single registered output slot.
// Latency is one cycle from the accepting edge to out_valid.
// A destination is only accepted when the free list is not empty.
// out_rsp holds steady while out_valid is high and out_ready is low.
// Single instruction per cycle, no flush.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rename_stage (
	input  logic                    clk,
	input  logic                    reset,

	// Instruction in
	input  logic                    in_valid,
	input  rename_pkg::rename_req_t in_req,
	output logic                    in_ready,

	// Renamed instruction out
	output logic                    out_valid,
	output rename_pkg::rename_rsp_t out_rsp,
	input  logic                    out_ready,

	// Free list
	input  rename_pkg::phys_tag_t   fl_head,
	input  logic                    fl_empty,
	output logic                    fl_pop,

	// Alias table
	input  rename_pkg::phys_tag_t   rat_prs1,
	input  rename_pkg::phys_tag_t   rat_prs2,
	input  rename_pkg::phys_tag_t   rat_old,
	output logic                    rat_wr_en,
	output rename_pkg::phys_tag_t   rat_wr_tag
);

	import rename_pkg::*;

	logic        slot_free;  // Slot empty or draining this cycle
	logic        dest_ok;    // Destination can be allocated
	logic        accept;
	logic        alloc;
	rename_rsp_t rsp_d;      // Response built from current lookups

	assign slot_free = !out_valid || out_ready;
	assign dest_ok   = !in_req.rd_valid || !fl_empty; // No rd needs no tag

	assign in_ready = slot_free && dest_ok;
	assign accept   = in_valid && in_ready;
	assign alloc    = accept && in_req.rd_valid;

	// Allocate the head tag and remap rd in the same edge
	assign fl_pop     = alloc;
	assign rat_wr_en  = alloc;
	assign rat_wr_tag = fl_head;

	// Sources are looked up before this instruction's own write
	always_comb begin
		rsp_d.prs1     = rat_prs1;
		rsp_d.prs2     = rat_prs2;
		rsp_d.rd_valid = in_req.rd_valid;
		if (in_req.rd_valid) begin
			rsp_d.prd     = fl_head;
			rsp_d.old_prd = rat_old;
		end else begin
			rsp_d.prd     = '0; // Nothing allocated
			rsp_d.old_prd = '0;
		end
	end

	// Slot occupancy
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (slot_free) begin
			out_valid <= accept; // Refill or go empty
		end
	end

	// Slot payload, loaded only on acceptance
	always_ff @(posedge clk) begin
		if (accept) begin
			out_rsp <= rsp_d;
		end
	end

endmodule

/* verilog/reg_alias_table.sv */
//////////////////////////////////////////////////////////////////////
// Register alias table, architectural to physical mapping.
// Reset maps entry i to physical tag i.
// Three combinational read ports, one write port taking effect at the
// clock edge. Reads see the state before a same-cycle write.
// No checkpoint or recovery support.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reg_alias_table #(
	parameter int NUM_ARCH = 32 // Architectural registers
) (
	input  logic                  clk,
	input  logic                  reset,

	// Source lookups
	input  rename_pkg::arch_tag_t rd_addr1,
	input  rename_pkg::arch_tag_t rd_addr2,
	output rename_pkg::phys_tag_t rd_tag1,
	output rename_pkg::phys_tag_t rd_tag2,

	// Current mapping of the destination, becomes old_prd
	input  rename_pkg::arch_tag_t old_addr,
	output rename_pkg::phys_tag_t old_tag,

	// New mapping of the destination
	input  logic                  wr_en,
	input  rename_pkg::arch_tag_t wr_addr,
	input  rename_pkg::phys_tag_t wr_tag
);

	import rename_pkg::*;

	// One physical tag per architectural register
	phys_tag_t map_q [NUM_ARCH];

	// Map state, identity after reset
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NUM_ARCH; i++) begin
				map_q[i] <= phys_tag_t'(i);
			end
		end else if (wr_en) begin
			map_q[wr_addr] <= wr_tag;
		end
	end

	// Read ports come from the register state only
	// so an instruction reading its own rd gets the old mapping
	assign rd_tag1 = map_q[rd_addr1];
	assign rd_tag2 = map_q[rd_addr2];
	assign old_tag = map_q[old_addr]; // Same array, third port

endmodule

/* free_list/free_list_fifo.sv */
//////////////////////////////////////////////////////////////////////
// Circular FIFO of free physical tags with an occupancy count.
// Reset preloads PRELOAD_COUNT ascending tags from PRELOAD_START.
// Push and pop are unguarded. The caller must never pop when empty
// and never push more tags than were popped, so it cannot overflow.
// A pushed tag is visible at head one cycle after its edge.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module free_list_fifo #(
	parameter int DEPTH_LOG2    = 6,  // log2 of entry count
	parameter int PRELOAD_START = 32, // First tag loaded at reset
	parameter int PRELOAD_COUNT = 32  // Tags loaded at reset
) (
	input  logic                  clk,
	input  logic                  reset,

	// Commit side
	input  logic                  push,
	input  rename_pkg::phys_tag_t push_tag,

	// Allocation side
	input  logic                  pop,
	output rename_pkg::phys_tag_t head,       // Tag at read pointer
	output logic                  empty,
	output logic [DEPTH_LOG2:0]   free_count  // Occupancy
);

	import rename_pkg::*;

	localparam int DEPTH = 1 << DEPTH_LOG2;

	typedef logic [DEPTH_LOG2-1:0] ptr_t;
	typedef logic [DEPTH_LOG2:0]   cnt_t;

	// Storage, no reset beyond the preloaded entries
	phys_tag_t fifo_mem [DEPTH];

	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t count;
	cnt_t count_next;

	// Occupancy update
	// Push with pop in one cycle keeps the count
	always_comb begin
		count_next = count;
		case ({push, pop})
			2'b10:   count_next = count + cnt_t'(1);
			2'b01:   count_next = count - cnt_t'(1);
			default: count_next = count; // Idle or both
		endcase
	end

	// Pointers, count and memory
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= ptr_t'(PRELOAD_COUNT); // Next slot after preload
			count  <= cnt_t'(PRELOAD_COUNT);
			// Load consecutive free tags in ascending order
			for (int i = 0; i < PRELOAD_COUNT; i++) begin
				fifo_mem[i] <= phys_tag_t'(PRELOAD_START + i);
			end
		end else begin
			if (push) begin
				fifo_mem[wr_ptr] <= push_tag;
				wr_ptr           <= wr_ptr + ptr_t'(1); // Wraps at DEPTH
			end
			if (pop) begin
				rd_ptr <= rd_ptr + ptr_t'(1);
			end
			count <= count_next;
		end
	end

	// Head is read straight from memory
	// A same-cycle push is not bypassed to head
	assign head = fifo_mem[rd_ptr];

	assign empty      = (count == '0);
	assign free_count = count;

endmodule

/* common/rename_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared sizes and types for the rename front end.
// Tag widths are fixed for 32 architectural and 64 physical registers.
// Other power-of-two sizes need these widths edited to match.
// x0 is renamed like any other register.
//////////////////////////////////////////////////////////////////////

package rename_pkg;

	// Register file sizes, used as top-level parameter defaults
	localparam int ARCH_REGS = 32;
	localparam int PHYS_REGS = 64;

	localparam int ARCH_TAG_W = $clog2(ARCH_REGS); // 5 bits
	localparam int PHYS_TAG_W = $clog2(PHYS_REGS); // 6 bits

	// Architectural register index
	typedef logic [ARCH_TAG_W-1:0] arch_tag_t;

	// Physical register index, also the free list word and the table entry
	typedef logic [PHYS_TAG_W-1:0] phys_tag_t;

	// Decoded instruction as seen by rename
	typedef struct packed {
		arch_tag_t rs1;      // Source 1
		arch_tag_t rs2;      // Source 2
		arch_tag_t rd;       // Destination, meaningful only with rd_valid
		logic      rd_valid; // Instruction writes a register
	} rename_req_t;

	// Renamed instruction
	// prd and old_prd read zero when rd_valid is clear
	typedef struct packed {
		phys_tag_t prs1;     // Physical source 1
		phys_tag_t prs2;     // Physical source 2
		phys_tag_t prd;      // Newly allocated destination
		phys_tag_t old_prd;  // Previous mapping of rd, freed at retire
		logic      rd_valid; // Copied from the request
	} rename_rsp_t;

endpackage
